// ==== verilog/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;

    typedef logic [4:0]           regAddrT;
    typedef logic [dataWidth-1:0] wordT;

    localparam regAddrT zeroReg = 5'd0;
    localparam regAddrT linkReg = 5'd31;   // jal writes its return address here

    // primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // function field of special, bits 5:0
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } functT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    typedef enum logic [1:0] {pcSequential, pcJump, pcBranch, pcRegister} pcSrcT;

    typedef enum logic [1:0] {fwdRegFile, fwdMemory, fwdWriteback} fwdSelT;

    typedef struct packed {
        aluOpT aluOp;
        logic  aluSrcImm;   // operand B is the extended immediate
        logic  link;        // result is the return address
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
        logic  memToReg;
    } ctrlT;

    typedef struct packed {
        ctrlT    ctrl;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
        wordT    operandA;
        wordT    operandB;
        wordT    extImm;
        logic [4:0] shamt;
        wordT    pcPlus8;
    } idExT;

    typedef struct packed {
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        logic    memToReg;
        regAddrT dest;
        wordT    aluResult;
        wordT    storeData;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        logic    memToReg;
        regAddrT dest;
        wordT    aluResult;
        wordT    loadData;
    } memWbT;

    // where decode's instruction needs each source operand
    typedef struct packed {
        logic rsDecode;
        logic rtDecode;
        logic rsExecute;
        logic rtExecute;
    } hazardT;

    // operand mux shared by the decode and execute forwarding points
    function automatic wordT forwardSelect(fwdSelT sel, wordT regVal, wordT memVal,
                                           wordT wbVal);
        case (sel)
            fwdMemory:    return memVal;
            fwdWriteback: return wbVal;
            default:      return regVal;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire mipsPkg::regAddrT rsAddr,
    input  wire mipsPkg::regAddrT rtAddr,
    input  wire mipsPkg::regAddrT writeAddr,
    input  wire mipsPkg::wordT    writeData,
    input  wire logic             regWrite,
    output mipsPkg::wordT         rsData,
    output mipsPkg::wordT         rtData
);

    mipsPkg::wordT regs [32];   // entry 0 is never written

    always_ff @(posedge clock) begin
        if (!reset && regWrite && writeAddr != mipsPkg::zeroReg) begin
            regs[writeAddr] <= writeData;
        end
    end

    // a write in the same cycle is seen by the read
    assign rsData = (rsAddr == mipsPkg::zeroReg) ? '0 :
                    (regWrite && writeAddr == rsAddr) ? writeData : regs[rsAddr];
    assign rtData = (rtAddr == mipsPkg::zeroReg) ? '0 :
                    (regWrite && writeAddr == rtAddr) ? writeData : regs[rtAddr];

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire mipsPkg::regAddrT rsAddr,
    input  wire mipsPkg::regAddrT rtAddr,
    input  wire mipsPkg::hazardT  hazard,
    input  wire mipsPkg::regAddrT exRs,
    input  wire mipsPkg::regAddrT exRt,
    input  wire mipsPkg::regAddrT exDest,
    input  wire mipsPkg::ctrlT    exCtrl,
    input  wire mipsPkg::exMemT   exMem,
    input  wire mipsPkg::regAddrT writeAddr,
    input  wire logic             regWrite,
    output logic                  fetchStall,
    output logic                  executeBubble,
    output mipsPkg::fwdSelT       decodeFwdRs,
    output mipsPkg::fwdSelT       decodeFwdRt,
    output mipsPkg::fwdSelT       executeFwdRs,
    output mipsPkg::fwdSelT       executeFwdRt
);

    // newest producer wins; register 0 is never forwarded
    function automatic mipsPkg::fwdSelT pickSource(mipsPkg::regAddrT addr);
        if (addr == mipsPkg::zeroReg) return mipsPkg::fwdRegFile;
        if (exMem.regWrite && exMem.dest == addr) return mipsPkg::fwdMemory;
        if (regWrite && writeAddr == addr) return mipsPkg::fwdWriteback;
        return mipsPkg::fwdRegFile;
    endfunction

    // true when an operand cannot be forwarded in time
    function automatic logic mustWait(mipsPkg::regAddrT addr, logic inDecode,
                                      logic inExecute);
        logic exMatch, memLoadMatch;
        exMatch      = exCtrl.regWrite && exDest == addr;
        memLoadMatch = exMem.memRead && exMem.dest == addr;
        if (addr == mipsPkg::zeroReg) return 1'b0;
        return (inDecode && (exMatch || memLoadMatch))
            || (inExecute && exMatch && exCtrl.memRead);   // load-use
    endfunction

    always_comb begin
        decodeFwdRs  = pickSource(rsAddr);
        decodeFwdRt  = pickSource(rtAddr);
        executeFwdRs = pickSource(exRs);
        executeFwdRt = pickSource(exRt);
        fetchStall   = mustWait(rsAddr, hazard.rsDecode, hazard.rsExecute)
                    || mustWait(rtAddr, hazard.rtDecode, hazard.rtExecute);
    end

    assign executeBubble = fetchStall;   // decode holds, so execute gets a nop

endmodule

`default_nettype wire

// ==== verilog/fetchDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchDecode #(
    parameter mipsPkg::wordT resetVector
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire mipsPkg::wordT    instData,
    input  wire logic             fetchStall,
    input  wire mipsPkg::fwdSelT  fwdRs,
    input  wire mipsPkg::fwdSelT  fwdRt,
    input  wire mipsPkg::wordT    memResult,
    input  wire mipsPkg::wordT    writeData,
    input  wire mipsPkg::wordT    rsData,
    input  wire mipsPkg::wordT    rtData,
    output logic [29:0]           instAddress,
    output mipsPkg::regAddrT      rsAddr,
    output mipsPkg::regAddrT      rtAddr,
    output mipsPkg::hazardT       hazard,
    output mipsPkg::idExT         idEx
);

    mipsPkg::wordT    pc, pcNext, pcPlus4;
    mipsPkg::wordT    instr, decPcPlus4;   // fetch-to-decode register
    mipsPkg::opcodeT  opcode;
    mipsPkg::functT   funct;
    mipsPkg::pcSrcT   pcSrc;
    mipsPkg::ctrlT    ctrl;
    mipsPkg::regAddrT dest;
    mipsPkg::wordT    rsValue, rtValue, extImm, branchTarget, jumpTarget;
    logic [15:0]      imm;
    logic             zeroExtend;

    assign pcPlus4     = pc + 32'd4;
    assign instAddress = pc[31:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= resetVector;
        end else if (!fetchStall) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            instr <= '0;   // sll $0 is a nop
        end else if (!fetchStall) begin
            instr      <= instData;
            decPcPlus4 <= pcPlus4;
        end
    end

    assign opcode = mipsPkg::opcodeT'(instr[31:26]);
    assign funct  = mipsPkg::functT'(instr[5:0]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign imm    = instr[15:0];
    assign extImm = zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // operands as seen in decode, used by the compare, jr and execute
    assign rsValue = mipsPkg::forwardSelect(fwdRs, rsData, memResult, writeData);
    assign rtValue = mipsPkg::forwardSelect(fwdRt, rtData, memResult, writeData);

    assign branchTarget = decPcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {decPcPlus4[31:28], instr[25:0], 2'b00};

    always_comb begin
        ctrl       = '0;
        hazard     = '0;
        pcSrc      = mipsPkg::pcSequential;
        dest       = rtAddr;
        zeroExtend = 1'b0;
        case (opcode)
            mipsPkg::opSpecial: begin
                dest             = instr[15:11];   // rd
                ctrl.regWrite    = 1'b1;
                hazard.rsExecute = 1'b1;
                hazard.rtExecute = 1'b1;
                case (funct)
                    mipsPkg::fnSll:  ctrl.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  ctrl.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSra:  ctrl.aluOp = mipsPkg::aluSra;
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnNor:  ctrl.aluOp = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnJr: begin
                        ctrl.regWrite   = 1'b0;
                        hazard          = '0;
                        hazard.rsDecode = 1'b1;   // target is needed right now
                        pcSrc           = mipsPkg::pcRegister;
                    end
                    default: begin   // unsupported function runs as a nop
                        ctrl.regWrite = 1'b0;
                        hazard        = '0;
                    end
                endcase
            end
            mipsPkg::opJ: pcSrc = mipsPkg::pcJump;
            mipsPkg::opJal: begin
                pcSrc         = mipsPkg::pcJump;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                dest          = mipsPkg::linkReg;
            end
            mipsPkg::opBeq, mipsPkg::opBne: begin
                hazard.rsDecode = 1'b1;
                hazard.rtDecode = 1'b1;
                if ((rsValue == rtValue) != (opcode == mipsPkg::opBne)) begin
                    pcSrc = mipsPkg::pcBranch;
                end
            end
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opAndi,
            mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
                ctrl.aluSrcImm   = 1'b1;
                ctrl.regWrite    = 1'b1;
                hazard.rsExecute = 1'b1;
                zeroExtend = opcode inside {mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori};
                case (opcode)
                    mipsPkg::opSlti: ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::opAndi: ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:  ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori: ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::opLui:  ctrl.aluOp = mipsPkg::aluLui;
                    default:         ctrl.aluOp = mipsPkg::aluAdd;
                endcase
            end
            mipsPkg::opLw: begin
                ctrl.aluSrcImm   = 1'b1;
                ctrl.memRead     = 1'b1;
                ctrl.memToReg    = 1'b1;
                ctrl.regWrite    = 1'b1;
                hazard.rsExecute = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.aluSrcImm   = 1'b1;
                ctrl.memWrite    = 1'b1;
                hazard.rsExecute = 1'b1;
                hazard.rtExecute = 1'b1;   // store data
            end
            default: ;
        endcase
    end

    always_comb begin
        case (pcSrc)
            mipsPkg::pcJump:     pcNext = jumpTarget;
            mipsPkg::pcBranch:   pcNext = branchTarget;
            mipsPkg::pcRegister: pcNext = rsValue;
            default:             pcNext = pcPlus4;
        endcase
    end

    assign idEx = '{ctrl: ctrl, rs: rsAddr, rt: rtAddr, dest: dest,
                    operandA: rsValue, operandB: rtValue, extImm: extImm,
                    shamt: instr[10:6], pcPlus8: decPcPlus4 + 32'd4};

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire mipsPkg::idExT   idExIn,
    input  wire logic            executeBubble,
    input  wire mipsPkg::fwdSelT fwdRs,
    input  wire mipsPkg::fwdSelT fwdRt,
    input  wire mipsPkg::wordT   writeData,
    output mipsPkg::regAddrT     exRs,
    output mipsPkg::regAddrT     exRt,
    output mipsPkg::regAddrT     exDest,
    output mipsPkg::ctrlT        exCtrl,
    output mipsPkg::exMemT       exMem
);

    mipsPkg::idExT idEx;
    mipsPkg::wordT srcA, srcB, aluB, aluResult;

    always_ff @(posedge clock) begin
        idEx <= idExIn;
        if (reset || executeBubble) begin
            idEx.ctrl <= '0;   // nop, nothing gets written
        end
    end

    assign exRs   = idEx.rs;
    assign exRt   = idEx.rt;
    assign exDest = idEx.dest;
    assign exCtrl = idEx.ctrl;

    assign srcA = mipsPkg::forwardSelect(fwdRs, idEx.operandA, exMem.aluResult, writeData);
    assign srcB = mipsPkg::forwardSelect(fwdRt, idEx.operandB, exMem.aluResult, writeData);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.extImm : srcB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            mipsPkg::aluSub:  aluResult = srcA - aluB;
            mipsPkg::aluAnd:  aluResult = srcA & aluB;
            mipsPkg::aluOr:   aluResult = srcA | aluB;
            mipsPkg::aluXor:  aluResult = srcA ^ aluB;
            mipsPkg::aluNor:  aluResult = ~(srcA | aluB);
            mipsPkg::aluSlt:  aluResult = mipsPkg::wordT'($signed(srcA) < $signed(aluB));
            mipsPkg::aluSltu: aluResult = mipsPkg::wordT'(srcA < aluB);
            mipsPkg::aluSll:  aluResult = aluB << idEx.shamt;
            mipsPkg::aluSrl:  aluResult = aluB >> idEx.shamt;
            mipsPkg::aluSra:  aluResult = $signed(aluB) >>> idEx.shamt;
            mipsPkg::aluLui:  aluResult = {aluB[15:0], 16'h0000};
            default:          aluResult = srcA + aluB;
        endcase
        if (idEx.ctrl.link) begin
            aluResult = idEx.pcPlus8;   // jal return address
        end
    end

    always_ff @(posedge clock) begin
        exMem.dest      <= idEx.dest;
        exMem.aluResult <= aluResult;
        exMem.storeData <= srcB;
        if (reset) begin
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
        end else begin
            exMem.memRead  <= idEx.ctrl.memRead;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memoryWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryWriteback (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire mipsPkg::exMemT exMem,
    input  wire mipsPkg::wordT  dataIn,
    output logic [29:0]         dataAddress,
    output logic                dataRead,
    output logic [3:0]          dataWrite,
    output mipsPkg::wordT       dataOut,
    output mipsPkg::regAddrT    writeAddr,
    output mipsPkg::wordT       writeData,
    output logic                regWrite
);

    mipsPkg::memWbT memWb;

    // memory answers in the same cycle, whole words only
    assign dataAddress = exMem.aluResult[31:2];
    assign dataRead    = exMem.memRead;
    assign dataWrite   = {4{exMem.memWrite}};
    assign dataOut     = exMem.storeData;

    always_ff @(posedge clock) begin
        memWb.dest      <= exMem.dest;
        memWb.aluResult <= exMem.aluResult;
        memWb.loadData  <= dataIn;
        if (reset) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
        end
    end

    assign writeAddr = memWb.dest;
    assign regWrite  = memWb.regWrite;
    assign writeData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// ==== verilog/mipsCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
    parameter mipsPkg::wordT resetVector = 32'hBFC0_0000
) (
    input  wire logic          clock,
    input  wire logic          reset,
    output logic [29:0]        instAddress,   // word address
    input  wire mipsPkg::wordT instData,
    output logic [29:0]        dataAddress,   // word address
    output logic               dataRead,
    output logic [3:0]         dataWrite,     // byte enables
    output mipsPkg::wordT      dataOut,
    input  wire mipsPkg::wordT dataIn
);

    mipsPkg::regAddrT rsAddr, rtAddr;
    mipsPkg::regAddrT exRs, exRt, exDest;
    mipsPkg::regAddrT writeAddr;
    mipsPkg::hazardT  hazard;
    mipsPkg::idExT    idEx;
    mipsPkg::ctrlT    exCtrl;
    mipsPkg::exMemT   exMem;
    mipsPkg::wordT    rsData, rtData, writeData;
    mipsPkg::fwdSelT  decodeFwdRs, decodeFwdRt, executeFwdRs, executeFwdRt;
    logic             regWrite;
    logic             fetchStall, executeBubble;

    fetchDecode #(.resetVector(resetVector)) frontEnd_i (
        .clock       (clock),
        .reset       (reset),
        .instData    (instData),
        .fetchStall  (fetchStall),
        .fwdRs       (decodeFwdRs),
        .fwdRt       (decodeFwdRt),
        .memResult   (exMem.aluResult),   // memory stage result
        .writeData   (writeData),
        .rsData      (rsData),
        .rtData      (rtData),
        .instAddress (instAddress),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .hazard      (hazard),
        .idEx        (idEx)
    );

    registerFile regFile_i (
        .clock     (clock),
        .reset     (reset),
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .regWrite  (regWrite),
        .rsData    (rsData),
        .rtData    (rtData)
    );

    hazardUnit hazard_i (
        .rsAddr        (rsAddr),
        .rtAddr        (rtAddr),
        .hazard        (hazard),
        .exRs          (exRs),
        .exRt          (exRt),
        .exDest        (exDest),
        .exCtrl        (exCtrl),
        .exMem         (exMem),
        .writeAddr     (writeAddr),
        .regWrite      (regWrite),
        .fetchStall    (fetchStall),
        .executeBubble (executeBubble),
        .decodeFwdRs   (decodeFwdRs),
        .decodeFwdRt   (decodeFwdRt),
        .executeFwdRs  (executeFwdRs),
        .executeFwdRt  (executeFwdRt)
    );

    executeStage execute_i (
        .clock         (clock),
        .reset         (reset),
        .idExIn        (idEx),
        .executeBubble (executeBubble),
        .fwdRs         (executeFwdRs),
        .fwdRt         (executeFwdRt),
        .writeData     (writeData),
        .exRs          (exRs),
        .exRt          (exRt),
        .exDest        (exDest),
        .exCtrl        (exCtrl),
        .exMem         (exMem)
    );

    memoryWriteback memWb_i (
        .clock       (clock),
        .reset       (reset),
        .exMem       (exMem),
        .dataIn      (dataIn),
        .dataAddress (dataAddress),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataOut     (dataOut),
        .writeAddr   (writeAddr),
        .writeData   (writeData),
        .regWrite    (regWrite)
    );

endmodule

`default_nettype wire

// ==== dv/mipsCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

    localparam mipsPkg::wordT resetVector = 32'hBFC0_0000;
    localparam int instWords = 512;
    localparam int dataWords = 256;

    logic          clock, reset;
    logic [29:0]   instAddress, dataAddress, instIndex;
    logic          dataRead;
    logic [3:0]    dataWrite;
    mipsPkg::wordT instData, dataOut, dataIn;

    mipsPkg::wordT instMem [instWords];
    mipsPkg::wordT dataMem [dataWords];
    mipsPkg::wordT refMem  [dataWords];   // data memory as the program sees it
    mipsPkg::wordT refRegs [32];
    logic [29:0]   expAddr [$];           // expected stores in program order
    mipsPkg::wordT expData [$];
    int            emitAt, progLen, storeIdx, writeCount, cycleCount, cycleLimit, spinAt;
    bit            executing, running;

    mipsCore #(.resetVector(resetVector)) dut_i (
        .clock       (clock),
        .reset       (reset),
        .instAddress (instAddress),
        .instData    (instData),
        .dataAddress (dataAddress),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .dataOut     (dataOut),
        .dataIn      (dataIn)
    );

    // both memories answer in the same cycle
    assign instIndex = instAddress - resetVector[31:2];
    assign instData  = (instIndex < instWords) ? instMem[instIndex] : '0;
    assign dataIn    = dataRead ? dataMem[dataAddress[7:0]] : '0;   // only a read returns data

    always @(posedge clock) begin
        if (dataWrite == 4'hF) begin
            dataMem[dataAddress[7:0]] <= dataOut;
        end
    end

    function automatic mipsPkg::wordT fillWord(int addr);
        return 32'h5A3C_0000 ^ (addr * 32'h0101_0F07);
    endfunction

    function automatic mipsPkg::wordT addrOf(int idx);
        return resetVector + 4 * idx;
    endfunction

    function automatic int newSlot();
        storeIdx++;
        return 4 * (storeIdx - 1);
    endfunction

    function automatic mipsPkg::wordT rFormat(mipsPkg::functT f, int rd, int rs, int rt, int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
    endfunction

    function automatic mipsPkg::wordT iFormat(mipsPkg::opcodeT op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mipsPkg::wordT regResult(mipsPkg::functT f, mipsPkg::wordT a,
                                                mipsPkg::wordT b, int sh);
        case (f)
            mipsPkg::fnAddu: return a + b;
            mipsPkg::fnSubu: return a - b;
            mipsPkg::fnAnd:  return a & b;
            mipsPkg::fnOr:   return a | b;
            mipsPkg::fnXor:  return a ^ b;
            mipsPkg::fnNor:  return ~(a | b);
            mipsPkg::fnSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mipsPkg::fnSltu: return (a < b) ? 32'd1 : 32'd0;
            mipsPkg::fnSll:  return b << sh;
            mipsPkg::fnSrl:  return b >> sh;
            mipsPkg::fnSra:  return $signed(b) >>> sh;
            default:         return 32'd0;
        endcase
    endfunction

    function automatic mipsPkg::wordT immResult(mipsPkg::opcodeT op, mipsPkg::wordT a,
                                                logic [15:0] imm);
        mipsPkg::wordT sext, zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            mipsPkg::opAddiu: return a + sext;
            mipsPkg::opSlti:  return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            mipsPkg::opAndi:  return a & zext;
            mipsPkg::opOri:   return a | zext;
            mipsPkg::opXori:  return a ^ zext;
            default:          return {imm, 16'h0000};   // lui
        endcase
    endfunction

    task automatic check(input bit ok, input string message);
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, message);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic emitWord(input mipsPkg::wordT word);
        instMem[emitAt] = word;
        emitAt++;
        if (emitAt > progLen) progLen = emitAt;
    endtask

    // the emit tasks below also step the reference model while executing is set
    task automatic aluReg(input mipsPkg::functT f, input int rd, input int rs, input int rt,
                          input int sh);
        emitWord(rFormat(f, rd, rs, rt, sh));
        if (executing && rd != 0) refRegs[rd] = regResult(f, refRegs[rs], refRegs[rt], sh);
    endtask

    task automatic aluImm(input mipsPkg::opcodeT op, input int rt, input int rs, input int imm);
        emitWord(iFormat(op, rs, rt, imm));
        if (executing && rt != 0) refRegs[rt] = immResult(op, refRegs[rs], 16'(imm));
    endtask

    task automatic storeWord(input int rt, input int offset);
        emitWord(iFormat(mipsPkg::opSw, 0, rt, offset));
        if (executing) begin
            expAddr.push_back(30'(offset >> 2));
            expData.push_back(refRegs[rt]);
            refMem[offset >> 2] = refRegs[rt];
        end
    endtask

    task automatic loadWord(input int rt, input int offset);
        emitWord(iFormat(mipsPkg::opLw, 0, rt, offset));
        if (executing && rt != 0) refRegs[rt] = refMem[offset >> 2];
    endtask

    task automatic loadConst(input int rd, input mipsPkg::wordT value);
        aluImm(mipsPkg::opLui, rd, 0, value[31:16]);
        aluImm(mipsPkg::opOri, rd, rd, value[15:0]);
    endtask

    task automatic jumpTo(input mipsPkg::opcodeT op, input int target);
        mipsPkg::wordT dest;
        dest = addrOf(target);
        if (executing && op == mipsPkg::opJal) refRegs[31] = addrOf(emitAt) + 8;
        emitWord({op, dest[27:2]});
    endtask

    // branch over one store; the delay slot store always runs
    task automatic branchOver(input mipsPkg::opcodeT op, input int rs, input int rt);
        bit taken;
        taken = (refRegs[rs] == refRegs[rt]) == (op == mipsPkg::opBeq);
        emitWord(iFormat(op, rs, rt, 2));
        storeWord(rs, newSlot());
        executing = !taken;
        storeWord(rt, newSlot());
        executing = 1'b1;
    endtask

    task automatic aluStep(input int sel, input int rd, input int a, input int b);
        int imm;
        imm = $urandom & 32'hFFFF;
        case (sel)
            0:  aluReg(mipsPkg::fnAddu, rd, a, b, 0);
            1:  aluReg(mipsPkg::fnSubu, rd, a, b, 0);
            2:  aluReg(mipsPkg::fnAnd, rd, a, b, 0);
            3:  aluReg(mipsPkg::fnOr, rd, a, b, 0);
            4:  aluReg(mipsPkg::fnXor, rd, a, b, 0);
            5:  aluReg(mipsPkg::fnNor, rd, a, b, 0);
            6:  aluReg(mipsPkg::fnSlt, rd, a, b, 0);
            7:  aluReg(mipsPkg::fnSltu, rd, a, b, 0);
            8:  aluReg(mipsPkg::fnSll, rd, 0, a, imm % 32);
            9:  aluReg(mipsPkg::fnSrl, rd, 0, a, imm % 32);
            10: aluReg(mipsPkg::fnSra, rd, 0, a, imm % 32);
            11: aluImm(mipsPkg::opAddiu, rd, a, imm);
            12: aluImm(mipsPkg::opSlti, rd, a, imm);
            13: aluImm(mipsPkg::opAndi, rd, a, imm);
            14: aluImm(mipsPkg::opOri, rd, a, imm);
            15: aluImm(mipsPkg::opXori, rd, a, imm);
            default: aluImm(mipsPkg::opLui, rd, 0, imm);
        endcase
    endtask

    task automatic buildProgram();
        int prev, prevPrev, rd, slot, base;
        executing = 1'b1;
        refRegs[0] = '0;
        // dependent chains with each result stored right away
        for (int c = 0; c < 3; c++) begin
            loadConst(1, $urandom);
            loadConst(2, $urandom);
            prev = 1;
            prevPrev = 2;
            for (int k = 0; k < 17; k++) begin
                rd = 3 + (c * 17 + k) % 8;
                aluStep((k * 7 + c) % 17, rd, prev, prevPrev);
                storeWord(rd, newSlot());
                prevPrev = prev;
                prev = rd;
            end
        end
        // load-use
        loadConst(11, $urandom);
        slot = newSlot();
        storeWord(11, slot);
        loadWord(12, slot);
        aluReg(mipsPkg::fnAddu, 13, 12, 11, 0);   // one bubble
        storeWord(13, newSlot());
        loadWord(14, slot);
        storeWord(14, newSlot());
        loadWord(0, slot);                        // r0 stays zero
        aluReg(mipsPkg::fnAddu, 15, 0, 11, 0);
        storeWord(0, newSlot());
        storeWord(15, newSlot());
        // branches
        loadWord(16, slot);
        branchOver(mipsPkg::opBeq, 16, 11);       // compare waits for the load
        aluImm(mipsPkg::opXori, 17, 11, 1);
        branchOver(mipsPkg::opBne, 17, 16);       // compare waits for the ALU
        branchOver(mipsPkg::opBeq, 17, 16);
        branchOver(mipsPkg::opBne, 11, 16);
        // jal to a subroutine emitted in execution order
        base = emitAt;
        jumpTo(mipsPkg::opJal, base + 5);
        storeWord(16, newSlot());
        emitAt = base + 5;
        storeWord(31, newSlot());
        aluReg(mipsPkg::fnJr, 0, 31, 0, 0);
        storeWord(11, newSlot());
        emitAt = base + 2;                        // return point
        storeWord(31, newSlot());
        jumpTo(mipsPkg::opJ, base + 8);
        storeWord(17, newSlot());
        emitAt = base + 8;
        spinAt = emitAt;
        emitWord(iFormat(mipsPkg::opBeq, 0, 0, -1));   // spin here
        emitWord('0);
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // store checker and cycle limit
    always @(negedge clock) begin
        if (running) begin
            cycleCount++;
            if (dataWrite != 4'h0) begin
                check(dataWrite == 4'hF, $sformatf("byte enables %b on a store", dataWrite));
                check(!dataRead, "read strobe high during a store");
                check(writeCount < expAddr.size(), "store beyond the expected sequence");
                check(dataAddress == expAddr[writeCount], $sformatf(
                      "store %0d address %h, expected %h", writeCount, dataAddress,
                      expAddr[writeCount]));
                check(dataOut == expData[writeCount], $sformatf(
                      "store %0d data %h, expected %h", writeCount, dataOut,
                      expData[writeCount]));
                writeCount++;
            end
            if (cycleCount > cycleLimit) begin
                $display("timeout after %0d cycles with %0d of %0d stores seen",
                         cycleCount, writeCount, expAddr.size());
                $display("** FAIL **");
                $fatal(1);
            end
        end
    end

    initial begin
        reset   = 1'b1;
        running = 1'b0;
        void'($urandom(69363));
        for (int i = 0; i < instWords; i++) instMem[i] = '0;
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i] = fillWord(i);
            refMem[i]  = fillWord(i);
        end
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        buildProgram();
        cycleLimit = 4 * progLen + 50;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check(instAddress == resetVector[31:2],
              $sformatf("first fetch address %h after reset", instAddress));
        check(dataRead == 1'b0 && dataWrite == 4'h0, "data port active after reset");
        running = 1'b1;
        while (instAddress != 30'(addrOf(spinAt) >> 2)) @(negedge clock);
        repeat (20) @(posedge clock);   // stores still in the pipeline land here
        if (writeCount == expAddr.size()) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("error at %0t ns: %0d stores seen, %0d expected", $time, writeCount,
                     expAddr.size());
            $display("** FAIL **");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/mipsPkg.sv
verilog/registerFile.sv
verilog/hazardUnit.sv
verilog/fetchDecode.sv
verilog/executeStage.sv
verilog/memoryWriteback.sv
verilog/mipsCore.sv
dv/mipsCoreTb.sv
